//--- Makefile
TOP := tb_dbg_status

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- design/dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Datapath word and transmit data width
`define DBG_WORD_W 32

// One label character
`define DBG_CHAR_W 8

// Printed fields per step without the line end
`define DBG_FIELD_NUM 9

// Longest label (NPC, CTL, IMM, MDR)
`define DBG_LABEL_MAX 3

`define DBG_ASCII_EQ 8'h3D
`define DBG_ASCII_CR 8'h0D
`define DBG_ASCII_LF 8'h0A

`endif

//--- design/dbg_field_seq.sv
`timescale 1ns/1ps
`include "dbg_defs.svh"

module dbg_field_seq (
    input  logic                clk,
    input  logic                rstn,
    input  logic                printing,
    input  logic                item_sent,
    input  dbg_pkg::dp_status_t status,
    output dbg_pkg::tx_item_t   item,
    output logic                item_ready,
    output logic                seq_done
);
    import dbg_pkg::*;

    field_e     fld;
    seq_phase_e phase;
    logic [1:0] char_idx;
    logic       run;
    logic       done_q; // Line sent and waiting for printing to drop
    label_t     lbl;
    logic       last_char;
    logic [1:0] char_sel;
    logic [3:0] word_sel;

    logic [`DBG_FIELD_NUM-1:0][`DBG_WORD_W-1:0] words;

    assign words      = status; // npc lands in the top slot
    assign lbl        = field_label(fld);
    assign last_char  = (char_idx == lbl.len - 2'd1);
    assign char_sel   = 2'(`DBG_LABEL_MAX - 1) - char_idx;
    assign word_sel   = 4'(`DBG_FIELD_NUM - 1) - fld;
    assign item_ready = run && printing;

    always_comb begin
        item = '0;
        case (phase)
            PH_LABEL: begin
                if (fld == F_EOL) begin
                    item.data[`DBG_CHAR_W-1:0] = (char_idx == 2'd0) ? `DBG_ASCII_CR
                                                                    : `DBG_ASCII_LF;
                end else begin
                    item.data[`DBG_CHAR_W-1:0] = lbl.chars[char_sel];
                end
            end
            PH_EQ: begin
                item.data[`DBG_CHAR_W-1:0] = `DBG_ASCII_EQ;
            end
            default: begin
                item.is_word = 1'b1;
                item.data    = words[word_sel];
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fld      <= F_NPC;
            phase    <= PH_LABEL;
            char_idx <= 2'd0;
            run      <= 1'b0;
            done_q   <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            if (!printing) begin
                fld      <= F_NPC; // Idle or abort
                phase    <= PH_LABEL;
                char_idx <= 2'd0;
                run      <= 1'b0;
                done_q   <= 1'b0;
            end else if (!run && !done_q) begin
                run <= 1'b1;
            end else if (run && item_sent) begin
                case (phase)
                    PH_LABEL: begin
                        if (fld == F_EOL) begin
                            if (char_idx == 2'd0) begin
                                char_idx <= 2'd1;
                            end else begin
                                run      <= 1'b0; // LF taken so the line is complete
                                done_q   <= 1'b1;
                                seq_done <= 1'b1;
                            end
                        end else if (last_char) begin
                            phase    <= PH_EQ;
                            char_idx <= 2'd0;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end
                    PH_EQ: begin
                        phase <= PH_WORD;
                    end
                    default: begin
                        phase <= PH_LABEL;
                        fld   <= field_e'(fld + 4'd1);
                    end
                endcase
            end
        end
    end

endmodule

//--- design/dbg_pkg.sv
package dbg_pkg;

`include "dbg_defs.svh"

    typedef enum logic [1:0] {
        IDLE,
        CLK_HIGH,
        CLK_LOW,
        PRINT
    } step_state_e;

    // Print order with F_EOL for CR and LF
    typedef enum logic [3:0] {
        F_NPC, F_PC, F_IR, F_CTL, F_A, F_B, F_IMM, F_Y, F_MDR, F_EOL
    } field_e;

    typedef enum logic [1:0] {
        PH_LABEL,
        PH_EQ,
        PH_WORD
    } seq_phase_e;

    typedef struct packed {
        logic [`DBG_WORD_W-1:0] npc;
        logic [`DBG_WORD_W-1:0] pc;
        logic [`DBG_WORD_W-1:0] ir;
        logic [`DBG_WORD_W-1:0] ctl;
        logic [`DBG_WORD_W-1:0] a;
        logic [`DBG_WORD_W-1:0] b;
        logic [`DBG_WORD_W-1:0] imm;
        logic [`DBG_WORD_W-1:0] y;
        logic [`DBG_WORD_W-1:0] mdr;
    } dp_status_t;

    typedef struct packed {
        logic                   is_word; // 0 means a character in the low byte
        logic [`DBG_WORD_W-1:0] data;
    } tx_item_t;

    // First character in the top byte and short labels padded below
    typedef struct packed {
        logic [1:0]                                     len;
        logic [`DBG_LABEL_MAX-1:0][`DBG_CHAR_W-1:0] chars;
    } label_t;

    function automatic label_t field_label(input field_e f);
        label_t l;
        case (f)
            F_NPC:   l = '{len: 2'd3, chars: "NPC"};
            F_PC:    l = '{len: 2'd2, chars: {"PC", 8'h00}};
            F_IR:    l = '{len: 2'd2, chars: {"IR", 8'h00}};
            F_CTL:   l = '{len: 2'd3, chars: "CTL"};
            F_A:     l = '{len: 2'd1, chars: {"A", 16'h0000}};
            F_B:     l = '{len: 2'd1, chars: {"B", 16'h0000}};
            F_IMM:   l = '{len: 2'd3, chars: "IMM"};
            F_Y:     l = '{len: 2'd1, chars: {"Y", 16'h0000}};
            F_MDR:   l = '{len: 2'd3, chars: "MDR"};
            default: l = '{len: 2'd0, chars: '0};
        endcase
        return l;
    endfunction

endpackage

//--- design/dbg_status_top.sv
`timescale 1ns/1ps
`include "dbg_defs.svh"

module dbg_status_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [7:0]             sel_mode,
    input  logic [7:0]             cmd_code,
    input  dbg_pkg::dp_status_t    status,
    input  logic                   ack_tx,
    output logic                   req_tx,
    output logic                   type_tx,
    output logic [`DBG_WORD_W-1:0] dout_tx,
    output logic                   clk_cpu,
    output logic                   finish
);
    import dbg_pkg::*;

    logic     printing;
    logic     seq_done;
    logic     item_ready;
    logic     item_sent;
    tx_item_t item;

    dbg_step_ctrl dbg_step_ctrl_i (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .cmd_code (cmd_code),
        .seq_done (seq_done),
        .clk_cpu  (clk_cpu),
        .printing (printing),
        .finish   (finish)
    );

    dbg_field_seq dbg_field_seq_i (
        .clk        (clk),
        .rstn       (rstn),
        .printing   (printing),
        .item_sent  (item_sent),
        .status     (status),
        .item       (item),
        .item_ready (item_ready),
        .seq_done   (seq_done)
    );

    dbg_tx_port dbg_tx_port_i (
        .clk        (clk),
        .rstn       (rstn),
        .item_ready (item_ready),
        .ack_tx     (ack_tx),
        .item       (item),
        .req_tx     (req_tx),
        .type_tx    (type_tx),
        .item_sent  (item_sent),
        .dout_tx    (dout_tx)
    );

endmodule

//--- design/dbg_step_ctrl.sv
`timescale 1ns/1ps

module dbg_step_ctrl (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] sel_mode,
    input  logic [7:0] cmd_code,
    input  logic       seq_done,
    output logic       clk_cpu,
    output logic       printing,
    output logic       finish
);
    import dbg_pkg::*;

    step_state_e state;
    step_state_e state_n;
    logic        sel;

    assign sel      = (sel_mode == cmd_code);
    assign printing = (state == PRINT);

    always_comb begin
        state_n = state;
        if (!sel) begin
            state_n = IDLE; // Deselect aborts the step
        end else begin
            case (state)
                IDLE: begin
                    state_n = CLK_HIGH;
                end
                CLK_HIGH: begin
                    state_n = CLK_LOW;
                end
                CLK_LOW: begin
                    state_n = PRINT;
                end
                PRINT: begin
                    if (seq_done) begin
                        state_n = IDLE; // Next step starts from IDLE if still selected
                    end
                end
                default: begin
                    state_n = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            clk_cpu <= 1'b0;
            finish  <= 1'b0;
        end else begin
            state   <= state_n;
            clk_cpu <= (state_n == CLK_HIGH); // High only while in CLK_HIGH
            finish  <= sel && printing && seq_done;
        end
    end

endmodule

//--- design/dbg_tx_port.sv
`timescale 1ns/1ps
`include "dbg_defs.svh"

module dbg_tx_port (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   item_ready,
    input  logic                   ack_tx,
    input  dbg_pkg::tx_item_t      item,
    output logic                   req_tx,
    output logic                   type_tx,
    output logic                   item_sent,
    output logic [`DBG_WORD_W-1:0] dout_tx
);

    // Same cycle as ack so the sequencer moves on as req drops
    assign item_sent = req_tx && ack_tx;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_tx <= 1'b0;
        end else if (!req_tx) begin
            req_tx <= item_ready;
        end else if (ack_tx || !item_ready) begin
            req_tx <= 1'b0; // Item taken or step aborted
        end
    end

    // Payload captured at launch and held under back-pressure
    always_ff @(posedge clk) begin
        if (!req_tx && item_ready) begin
            type_tx <= item.is_word;
            dout_tx <= item.data;
        end
    end

endmodule

//--- src.f
+incdir+design
design/dbg_pkg.sv
design/dbg_step_ctrl.sv
design/dbg_field_seq.sv
design/dbg_tx_port.sv
design/dbg_status_top.sv
tb/tb_dbg_status.sv

//--- tb/tb_dbg_status.sv
`timescale 1ns/1ps
`include "dbg_defs.svh"

module tb_dbg_status;
    import dbg_pkg::*;

    typedef struct packed {
        logic [7:0]  cmd;
        logic [7:0]  sel;
        logic [31:0] base;     // Seed value for the nine status words
        int          steps;
        int          abort_at; // Items acked before deselect or 0 for none
    } row_t;

    localparam int NUM_ROWS = 6;
    localparam int ITEMS    = 39;

    logic                   clk;
    logic                   rstn;
    logic [7:0]             sel_mode;
    logic [7:0]             cmd_code;
    dp_status_t             status;
    logic                   ack_tx;
    logic                   req_tx;
    logic                   type_tx;
    logic [`DBG_WORD_W-1:0] dout_tx;
    logic                   clk_cpu;
    logic                   finish;

    row_t        rows [NUM_ROWS];
    logic [32:0] exp_items [ITEMS]; // {type, data} in send order
    logic [32:0] held_item;
    dp_status_t  cur_status;
    dp_status_t  drive_status;
    logic        scramble;
    logic        active;
    logic        cpu_prev = 1'b0;
    logic        fin_prev = 1'b0;
    logic        req_prev = 1'b0;
    logic        cpu_seen = 1'b0;
    int          errors;
    int          cycles;
    int          cycle_limit;
    int          item_idx;
    int          ack_wait;
    int          cpu_pulses;
    int          req_rises;
    int          finishes;
    int          items_acked;

    dbg_status_top dbg_status_top_i (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .cmd_code (cmd_code),
        .status   (status),
        .ack_tx   (ack_tx),
        .req_tx   (req_tx),
        .type_tx  (type_tx),
        .dout_tx  (dout_tx),
        .clk_cpu  (clk_cpu),
        .finish   (finish)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic report_mismatch(input string name, input logic [32:0] exp,
                                   input logic [32:0] got);
        $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
        errors++;
    endtask

    function automatic dp_status_t make_status(input logic [31:0] base);
        dp_status_t st;
        st.npc = base;
        st.pc  = base + 32'h0000_0004;
        st.ir  = ~base;
        st.ctl = {base[15:0], base[31:16]};
        st.a   = base ^ 32'ha5a5_a5a5;
        st.b   = base + 32'h1111_1111;
        st.imm = base >> 3;
        st.y   = base ^ 32'h0f0f_f0f0;
        st.mdr = base - 32'h0000_0100;
        return st;
    endfunction

    task automatic build_expected(input dp_status_t st);
        string       names [9];
        logic [31:0] words [9];
        int          n;
        int          f;
        int          c;
        names = '{"NPC", "PC", "IR", "CTL", "A", "B", "IMM", "Y", "MDR"};
        words = '{st.npc, st.pc, st.ir, st.ctl, st.a, st.b, st.imm, st.y, st.mdr};
        n = 0;
        for (f = 0; f < 9; f++) begin
            for (c = 0; c < names[f].len(); c++) begin
                exp_items[n] = {1'b0, 24'h0, names[f][c]};
                n++;
            end
            exp_items[n]     = {1'b0, 24'h0, `DBG_ASCII_EQ};
            exp_items[n + 1] = {1'b1, words[f]};
            n += 2;
        end
        exp_items[n]     = {1'b0, 24'h0, `DBG_ASCII_CR};
        exp_items[n + 1] = {1'b0, 24'h0, `DBG_ASCII_LF};
    endtask

    // Status flips while a word is in flight and dout_tx must hold
    always @(posedge clk) begin
        scramble     = req_tx && type_tx;
        drive_status = cur_status;
        #1;
        status = scramble ? dp_status_t'(~drive_status) : drive_status;
    end

    // Transmitter model and output checks
    always @(posedge clk) begin
        active = rstn;
        #1;
        if (active) begin
            if (clk_cpu) begin
                if (cpu_prev)
                    report_error("clk_cpu high for more than one cycle");
                if (req_tx)
                    report_error("clk_cpu pulse while req_tx is high");
                cpu_pulses++;
                cpu_seen = 1'b1;
                item_idx = 0; // New step restarts the stream
            end
            if (finish) begin
                if (fin_prev)
                    report_error("finish high for more than one cycle");
                if (item_idx != ITEMS)
                    report_mismatch("items before finish", 33'(ITEMS), 33'(item_idx));
                finishes++;
                cpu_seen = 1'b0;
            end
            if (ack_tx) begin
                ack_tx = 1'b0;
                if (req_tx)
                    report_error("req_tx still high in the cycle after ack");
            end else if (req_tx) begin
                if (!req_prev) begin
                    req_rises++;
                    held_item = {type_tx, dout_tx};
                    ack_wait  = int'($urandom % 4);
                    if (!cpu_seen)
                        report_error("req_tx rose without a clk_cpu pulse in this step");
                end else if ({type_tx, dout_tx} !== held_item) begin
                    report_mismatch("{type_tx,dout_tx} held", held_item, {type_tx, dout_tx});
                end
                if (ack_wait > 0) begin
                    ack_wait--;
                end else begin
                    ack_tx = 1'b1;
                    if (item_idx >= ITEMS)
                        report_error("more than 39 items sent in one step");
                    else if ({type_tx, dout_tx} !== exp_items[item_idx])
                        report_mismatch("{type_tx,dout_tx}", exp_items[item_idx],
                                        {type_tx, dout_tx});
                    item_idx++;
                    items_acked++;
                end
            end
            cpu_prev = clk_cpu;
            fin_prev = finish;
            req_prev = req_tx;
        end
    end

    task automatic run_row(input row_t row);
        int base_items;
        int base_fin;
        int base_cpu;
        int base_req;
        @(posedge clk);
        build_expected(make_status(row.base));
        #1;
        cmd_code   = row.cmd;
        sel_mode   = ~row.cmd;
        cur_status = make_status(row.base);
        repeat (3) @(posedge clk);
        base_items = items_acked;
        base_fin   = finishes;
        base_cpu   = cpu_pulses;
        base_req   = req_rises;
        #1;
        sel_mode = row.sel;
        if (row.sel != row.cmd) begin
            repeat (40) @(posedge clk);
            if (cpu_pulses != base_cpu || req_rises != base_req)
                report_error("clk_cpu or req_tx active while the unit is not selected");
            return;
        end
        if (row.abort_at > 0) begin
            @(posedge clk);
            while (items_acked - base_items < row.abort_at)
                @(posedge clk);
            #1;
            sel_mode = ~row.cmd;
            repeat (3) @(posedge clk);
            if (req_tx)
                report_error("req_tx still high two cycles after deselect");
            repeat (10) @(posedge clk);
            if (finishes != base_fin)
                report_error("finish pulsed for an aborted step");
            base_items = items_acked;
            base_cpu   = cpu_pulses;
            #1;
            sel_mode = row.sel; // Fresh step from the NPC label
        end
        @(posedge clk);
        while (finishes - base_fin < row.steps)
            @(posedge clk);
        #1;
        sel_mode = ~row.cmd;
        repeat (4) @(posedge clk);
        if (finishes - base_fin != row.steps)
            report_mismatch("finish count", 33'(row.steps), 33'(finishes - base_fin));
        if (items_acked - base_items != row.steps * ITEMS)
            report_mismatch("items acked", 33'(row.steps * ITEMS), 33'(items_acked - base_items));
        // Selection still held at the closing edge starts one more step
        if (cpu_pulses - base_cpu != row.steps + 1)
            report_mismatch("clk_cpu pulses", 33'(row.steps + 1), 33'(cpu_pulses - base_cpu));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, DUT stopped making progress", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h5a49_ef6a));
        rstn       = 1'b0;
        sel_mode   = 8'h00;
        cmd_code   = 8'hff;
        status     = '0;
        cur_status = '0;
        ack_tx     = 1'b0;
        rows[0] = '{8'h21, 8'h21, 32'h1234_5678, 2, 0};
        rows[1] = '{8'h21, 8'h22, 32'h9abc_def0, 1, 0};
        rows[2] = '{8'h05, 8'h05, 32'hdead_beef, 1, 12};
        rows[3] = '{8'h7f, 8'h7f, 32'h0000_0001, 3, 0};
        rows[4] = '{8'h40, 8'h40, 32'hcafe_f00d, 1, 38}; // Abort just before LF
        rows[5] = '{8'hc3, 8'h3c, 32'hffff_fffe, 1, 0};
        cycle_limit = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            cycle_limit += (rows[r].steps + 1) * ITEMS * 6 + 200;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        if (clk_cpu || req_tx || finish)
            report_error("clk_cpu, req_tx or finish not low after reset");
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(rows[r]);
        repeat (5) @(posedge clk);
        $display("Checks done: %0d errors, %0d items acked, %0d steps finished",
                 errors, items_acked, finishes);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
